/* hdl/cfg_pkg.sv */
// Register map for one 32-bit host port, 8-bit byte address, word access only, no byte lanes
`default_nettype none

package cfg_pkg;

    // *******************************************************************
    // Host bus and address split
    // *******************************************************************
    localparam int DATA_W     = 32;
    localparam int ADR_W      = 8;
    localparam int IDX_LSB    = 2;                      // Byte offset below the word index
    localparam int REGION_LSB = 5;                      // Bits 7:5 region, 4:2 word
    localparam int REGION_W   = ADR_W - REGION_LSB;
    localparam int IDX_W      = REGION_LSB - IDX_LSB;

    // Field and region sizes
    localparam int ACT_IDX_W  = 15;                     // Input counter limit
    localparam int OUT_IDX_W  = 15;                     // Repetition counts
    localparam int TH_W       = 2;                      // Zero-detect threshold
    localparam int CFG_BITS   = ACT_IDX_W + 2*OUT_IDX_W + TH_W + 2;
    localparam int CFG_WORDS  = 2;
    localparam int CFG_WIDX_W = $clog2(CFG_WORDS);
    localparam int SRAM_N     = 3;                      // Double-buffered SRAMs
    localparam int CODE_W     = 5;                      // Width of one FSM status code
    localparam int STATUS_W   = 3 + 3*CODE_W;           // 3 deadlock flags and 3 codes

    // *******************************************************************
    // Control register bit positions
    // *******************************************************************
    localparam int BIT_START        = 0;
    localparam int BIT_DONE         = 1;                // Clear on write of 1
    localparam int BIT_IDLE         = 2;
    localparam int BIT_READY        = 3;
    localparam int BIT_AUTO_RESTART = 7;
    localparam int BIT_MEM_SWITCH   = 16;
    localparam int BIT_KEEP_LSB     = 17;               // One keep bit per SRAM
    localparam int BIT_SOFT_RST     = 23;

    // Fixed read values
    localparam logic [7:0]        CTRL_TAG      = 8'hAC;
    localparam logic [DATA_W-1:0] BAD_ADDR_DATA = 32'h2BADADD2;

    // Region field of the address
    typedef enum logic [REGION_W-1:0] {
        REGION_SPECIAL = 3'd0,
        REGION_CON     = 3'd1
    } cfg_region_e;

    // Word index inside the special region
    typedef enum logic [IDX_W-1:0] {
        REG_CTRL   = 3'd0,
        REG_GIEN   = 3'd1,
        REG_DIEN   = 3'd2,
        REG_ISTAT  = 3'd3,
        REG_STATUS = 3'd4,
        REG_CYCLES = 3'd5,
        REG_STALLS = 3'd6
    } cfg_reg_e;

endpackage

`default_nettype wire

/* hdl/cfg_bus_decode.sv */
// Host writes act on the i_wren edge; read data lands one cycle after i_rden and holds
`timescale 1ns/1ps
`default_nettype none

module cfg_bus_decode import cfg_pkg::*; (
    input  wire                   i_clk,
    input  wire                   i_rstn,
    input  wire  [ADR_W-1:0]      i_address,
    input  wire                   i_wren,
    input  wire                   i_rden,
    input  wire  [DATA_W-1:0]     i_ctrl_word,      // Control word with tag
    input  wire                   i_gien,
    input  wire                   i_dien,
    input  wire                   i_istat,
    input  wire  [STATUS_W-1:0]   i_status_word,
    input  wire  [DATA_W-1:0]     i_cycles,
    input  wire  [DATA_W-1:0]     i_stalls,
    input  wire  [DATA_W-1:0]     i_con_word,       // Working word at o_word_idx
    output logic                  o_we_ctrl,
    output logic                  o_we_gien,
    output logic                  o_we_dien,
    output logic                  o_we_istat,
    output logic                  o_we_con,
    output logic [IDX_W-1:0]      o_word_idx,
    output logic [DATA_W-1:0]     o_data_out
);

    cfg_region_e       region;
    cfg_reg_e          reg_idx;
    logic              special_wr;
    logic              con_hit;                     // Index inside the config region
    logic [DATA_W-1:0] rd_data;

    // Address split
    assign region     = cfg_region_e'(i_address[ADR_W-1:REGION_LSB]);
    assign o_word_idx = i_address[REGION_LSB-1:IDX_LSB];
    assign reg_idx    = cfg_reg_e'(o_word_idx);
    assign con_hit    = (region == REGION_CON) && (o_word_idx < IDX_W'(CFG_WORDS));

    // Write strobes, one per write at most
    assign special_wr = i_wren && (region == REGION_SPECIAL);
    assign o_we_ctrl  = special_wr && (reg_idx == REG_CTRL);
    assign o_we_gien  = special_wr && (reg_idx == REG_GIEN);
    assign o_we_dien  = special_wr && (reg_idx == REG_DIEN);
    assign o_we_istat = special_wr && (reg_idx == REG_ISTAT);
    assign o_we_con   = i_wren && con_hit;

    // *******************************************************************
    // Read mux
    // *******************************************************************
    always_comb begin
        rd_data = BAD_ADDR_DATA;                    // Unmapped default
        case (region)
            REGION_SPECIAL: begin
                case (reg_idx)
                    REG_CTRL:   rd_data = i_ctrl_word;
                    REG_GIEN:   rd_data = DATA_W'(i_gien);
                    REG_DIEN:   rd_data = DATA_W'(i_dien);
                    REG_ISTAT:  rd_data = DATA_W'(i_istat);
                    REG_STATUS: rd_data = DATA_W'(i_status_word);   // Upper bits zero
                    REG_CYCLES: rd_data = i_cycles;
                    REG_STALLS: rd_data = i_stalls;
                    default:    rd_data = BAD_ADDR_DATA;
                endcase
            end
            REGION_CON: begin
                if (con_hit) rd_data = i_con_word;
            end
            default: rd_data = BAD_ADDR_DATA;
        endcase
    end

    // Read data register, holds until the next read
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_data_out <= '0;
        end else if (i_rden) begin
            o_data_out <= rd_data;
        end
    end

    // Only one target register per bus write
    a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $onehot0({o_we_ctrl, o_we_gien, o_we_dien, o_we_istat, o_we_con}));

endmodule

`default_nettype wire

/* hdl/cfg_ctrl_regs.sv */
// Idle and ready simply follow i_done; start is ignored unless ready was high
`timescale 1ns/1ps
`default_nettype none

module cfg_ctrl_regs import cfg_pkg::*; (
    input  wire                   i_clk,
    input  wire                   i_rstn,
    input  wire  [DATA_W-1:0]     i_data_in,
    input  wire  [DATA_W-1:0]     i_wmask,          // Bitwise write enable
    input  wire                   i_we_ctrl,
    input  wire                   i_we_gien,
    input  wire                   i_we_dien,
    input  wire                   i_we_istat,
    input  wire                   i_done,           // Datapath completion level
    input  wire                   i_act_deadlock,
    input  wire                   i_wei_deadlock,
    input  wire                   i_feed_deadlock,
    input  wire  [CODE_W-1:0]     i_ctx_status,
    input  wire  [CODE_W-1:0]     i_feed_status,
    input  wire  [CODE_W-1:0]     i_out_status,
    output logic [DATA_W-1:0]     o_ctrl_word,
    output logic                  o_gien,
    output logic                  o_dien,
    output logic                  o_istat,
    output logic [STATUS_W-1:0]   o_status_word,
    output logic                  o_start_accept,
    output logic                  o_start,
    output logic                  o_mem_switch_edge,
    output logic [SRAM_N-1:0]     o_mem_keep,
    output logic                  o_done_flag,
    output logic                  o_soft_reset,
    output logic                  o_doneintr
);

    logic              start_q, start_prv_q;
    logic              mem_switch_q, mem_switch_prv_q;
    logic              soft_rst_q, soft_rst_prv_q;
    logic              idle_q, idle_prv_q, ready_q;
    logic              auto_restart_q;
    logic              idle_edge;
    logic [SRAM_N-1:0] keep_mask;

    assign keep_mask = i_wmask[BIT_KEEP_LSB +: SRAM_N];
    assign idle_edge = idle_q & ~idle_prv_q;        // Datapath just finished

    // *******************************************************************
    // Control, interrupt and status registers
    // *******************************************************************
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            start_q <= 1'b0;
            start_prv_q <= 1'b0;
            mem_switch_q <= 1'b0;
            mem_switch_prv_q <= 1'b0;
            soft_rst_q <= 1'b0;
            soft_rst_prv_q <= 1'b0;
            idle_q <= 1'b1;
            idle_prv_q <= 1'b1;                     // No done flag out of reset
            ready_q <= 1'b1;
            auto_restart_q <= 1'b0;
            o_mem_keep <= '0;
            o_done_flag <= 1'b0;
            o_gien <= 1'b0;
            o_dien <= 1'b0;
            o_istat <= 1'b0;
            o_status_word <= '0;
        end else begin
            start_prv_q <= start_q;
            mem_switch_prv_q <= mem_switch_q;
            soft_rst_prv_q <= soft_rst_q;
            idle_q <= i_done;
            ready_q <= i_done;
            idle_prv_q <= idle_q;
            o_status_word <= {i_out_status, i_feed_status, i_ctx_status,
                              i_feed_deadlock, i_wei_deadlock, i_act_deadlock};

            // Pulse bits drop back unless written again
            start_q <= 1'b0;
            mem_switch_q <= 1'b0;
            soft_rst_q <= 1'b0;

            if (i_we_ctrl) begin
                if (i_wmask[BIT_START])        start_q <= i_data_in[BIT_START];
                if (i_wmask[BIT_DONE] && i_data_in[BIT_DONE]) o_done_flag <= 1'b0;
                if (i_wmask[BIT_AUTO_RESTART]) auto_restart_q <= i_data_in[BIT_AUTO_RESTART];
                if (i_wmask[BIT_MEM_SWITCH])   mem_switch_q <= i_data_in[BIT_MEM_SWITCH];
                if (i_wmask[BIT_SOFT_RST])     soft_rst_q <= i_data_in[BIT_SOFT_RST];
                o_mem_keep <= (o_mem_keep & ~keep_mask) |
                              (i_data_in[BIT_KEEP_LSB +: SRAM_N] & keep_mask);
            end
            if (i_we_gien && i_wmask[0]) o_gien <= i_data_in[0];
            if (i_we_dien && i_wmask[0]) o_dien <= i_data_in[0];
            if (i_we_istat && i_wmask[0] && i_data_in[0]) o_istat <= 1'b0;  // Clear on write

            // Completion wins over a clear in the same cycle
            if (idle_edge) begin
                o_done_flag <= 1'b1;
                o_istat <= 1'b1;
            end
        end
    end

    // Edge detection, start only counts while ready
    assign o_start_accept    = start_q & ~start_prv_q & ready_q;
    assign o_start           = o_start_accept;
    assign o_mem_switch_edge = mem_switch_q & ~mem_switch_prv_q;
    assign o_soft_reset      = soft_rst_q & ~soft_rst_prv_q;
    assign o_doneintr        = o_istat & o_gien & o_dien;

    // Control word as seen by the host
    always_comb begin
        o_ctrl_word = '0;
        o_ctrl_word[BIT_START] = start_q;
        o_ctrl_word[BIT_DONE] = o_done_flag;
        o_ctrl_word[BIT_IDLE] = idle_q;
        o_ctrl_word[BIT_READY] = ready_q;
        o_ctrl_word[BIT_AUTO_RESTART] = auto_restart_q;
        o_ctrl_word[BIT_MEM_SWITCH] = mem_switch_q;
        o_ctrl_word[BIT_KEEP_LSB +: SRAM_N] = o_mem_keep;
        o_ctrl_word[BIT_SOFT_RST] = soft_rst_q;
        o_ctrl_word[DATA_W-1 -: 8] = CTRL_TAG;      // Block identification
    end

    // A single start write never yields a two-cycle start
    a_start_pulse: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_start |=> !o_start);

endmodule

`default_nettype wire

/* hdl/cfg_perf_counters.sv */
// Counters wrap silently at 2**32; they are meaningful only after the done flag
`timescale 1ns/1ps
`default_nettype none

module cfg_perf_counters import cfg_pkg::*; (
    input  wire               i_clk,
    input  wire               i_rstn,
    input  wire               i_start_accept,
    input  wire               i_done_flag,
    input  wire               i_pipeline_en,    // Low means hard stall
    input  wire               i_pop_en,         // Low means soft stall
    output logic [DATA_W-1:0] o_cycles,
    output logic [DATA_W-1:0] o_stalls
);

    logic count_en_q;
    logic done_prv_q;
    logic done_edge;

    assign done_edge = i_done_flag & ~done_prv_q;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            count_en_q <= 1'b0;
            done_prv_q <= 1'b0;
            o_cycles <= '0;
            o_stalls <= '0;
        end else begin
            done_prv_q <= i_done_flag;
            if (i_start_accept) begin               // New layer, restart from zero
                count_en_q <= 1'b1;
                o_cycles <= '0;
                o_stalls <= '0;
            end else begin
                if (done_edge) count_en_q <= 1'b0;  // Values are kept for the host
                if (count_en_q) begin
                    o_cycles <= o_cycles + 1'b1;
                    if (!i_pipeline_en || !i_pop_en) o_stalls <= o_stalls + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cfg_sram_select.sv */
// A start and a memory switch in the same cycle toggle a select only once
`timescale 1ns/1ps
`default_nettype none

module cfg_sram_select import cfg_pkg::*; (
    input  wire               i_clk,
    input  wire               i_rstn,
    input  wire               i_start_accept,
    input  wire               i_mem_switch_edge,
    input  wire  [SRAM_N-1:0] i_mem_keep,       // Set bit freezes that SRAM
    output logic [SRAM_N-1:0] o_sram_select
);

    logic swap;

    assign swap = i_start_accept | i_mem_switch_edge;

    // Ping-pong buffer select, one bit per SRAM
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_sram_select <= '0;
        end else if (swap) begin
            o_sram_select <= o_sram_select ^ ~i_mem_keep;
        end
    end

endmodule

`default_nettype wire

/* hdl/cfg_shadow_regs.sv */
// Only the low CFG_BITS of the working words reach the datapath; higher bits are scratch
`timescale 1ns/1ps
`default_nettype none

module cfg_shadow_regs import cfg_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_rstn,
    input  wire  [DATA_W-1:0]      i_data_in,
    input  wire  [DATA_W-1:0]      i_wmask,
    input  wire                    i_we_con,        // Index already range checked
    input  wire  [IDX_W-1:0]       i_word_idx,
    input  wire                    i_start_accept,
    output logic [DATA_W-1:0]      o_con_word,      // Working word for read-back
    output logic [ACT_IDX_W-1:0]   o_incntlim,
    output logic [OUT_IDX_W-1:0]   o_act_reps,
    output logic [OUT_IDX_W-1:0]   o_wei_reps,
    output logic [TH_W-1:0]        o_thres,
    output logic                   o_sram_deepsleep,
    output logic                   o_sram_powergate
);

    logic [CFG_WORDS-1:0][DATA_W-1:0] work_q;      // Host-side copy
    logic [CFG_WORDS*DATA_W-1:0]      work_flat;
    logic [CFG_BITS-1:0]              shadow_q;    // Copy seen by the datapath
    logic [CFG_WIDX_W-1:0]            widx;

    assign widx      = i_word_idx[CFG_WIDX_W-1:0];
    assign work_flat = work_q;

    // *******************************************************************
    // Working copy and start-time shadow copy
    // *******************************************************************
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            work_q <= '0;
            shadow_q <= '0;
        end else begin
            if (i_we_con) begin
                work_q[widx] <= (work_q[widx] & ~i_wmask) | (i_data_in & i_wmask);
            end
            if (i_start_accept) shadow_q <= work_flat[CFG_BITS-1:0];
        end
    end

    assign o_con_word = work_q[widx];

    // Field unpack, bit 0 upward
    assign {o_sram_powergate, o_sram_deepsleep, o_thres,
            o_wei_reps, o_act_reps, o_incntlim} = shadow_q;

endmodule

`default_nettype wire

/* hdl/cfg_regs_top.sv */
// Configuration outputs change only on an accepted start; host may rewrite them meanwhile
`timescale 1ns/1ps
`default_nettype none

module cfg_regs_top import cfg_pkg::*; (
    input  wire                   i_clk,
    input  wire                   i_rstn,
    input  wire  [ADR_W-1:0]      i_address,
    input  wire  [DATA_W-1:0]     i_data_in,
    input  wire  [DATA_W-1:0]     i_wmask,
    input  wire                   i_wren,
    input  wire                   i_rden,
    input  wire                   i_done,
    input  wire                   i_act_deadlock,
    input  wire                   i_wei_deadlock,
    input  wire                   i_feed_deadlock,
    input  wire  [CODE_W-1:0]     i_ctx_status,
    input  wire  [CODE_W-1:0]     i_feed_status,
    input  wire  [CODE_W-1:0]     i_out_status,
    input  wire                   i_pipeline_en,
    input  wire                   i_pop_en,
    output logic [DATA_W-1:0]     o_data_out,
    output logic                  o_start,
    output logic                  o_soft_reset,
    output logic                  o_doneintr,
    output logic [SRAM_N-1:0]     o_sram_select,
    output logic [ACT_IDX_W-1:0]  o_incntlim,
    output logic [OUT_IDX_W-1:0]  o_act_reps,
    output logic [OUT_IDX_W-1:0]  o_wei_reps,
    output logic [TH_W-1:0]       o_thres,
    output logic                  o_sram_deepsleep,
    output logic                  o_sram_powergate
);

    // Write strobes
    logic we_ctrl, we_gien, we_dien, we_istat, we_con;
    logic [IDX_W-1:0] word_idx;

    // Read-back values
    logic [DATA_W-1:0]   ctrl_word, cycles, stalls, con_word;
    logic [STATUS_W-1:0] status_word;
    logic                gien, dien, istat;

    // Control events
    logic              start_accept, mem_switch_edge, done_flag;
    logic [SRAM_N-1:0] mem_keep;

    cfg_bus_decode u_decode (
        .i_clk, .i_rstn, .i_address, .i_wren, .i_rden,
        .i_ctrl_word(ctrl_word), .i_gien(gien), .i_dien(dien), .i_istat(istat),
        .i_status_word(status_word), .i_cycles(cycles), .i_stalls(stalls),
        .i_con_word(con_word),
        .o_we_ctrl(we_ctrl), .o_we_gien(we_gien), .o_we_dien(we_dien),
        .o_we_istat(we_istat), .o_we_con(we_con), .o_word_idx(word_idx),
        .o_data_out
    );

    cfg_ctrl_regs u_ctrl (
        .i_clk, .i_rstn, .i_data_in, .i_wmask,
        .i_we_ctrl(we_ctrl), .i_we_gien(we_gien), .i_we_dien(we_dien),
        .i_we_istat(we_istat), .i_done,
        .i_act_deadlock, .i_wei_deadlock, .i_feed_deadlock,
        .i_ctx_status, .i_feed_status, .i_out_status,
        .o_ctrl_word(ctrl_word), .o_gien(gien), .o_dien(dien), .o_istat(istat),
        .o_status_word(status_word), .o_start_accept(start_accept), .o_start,
        .o_mem_switch_edge(mem_switch_edge), .o_mem_keep(mem_keep),
        .o_done_flag(done_flag), .o_soft_reset, .o_doneintr
    );

    cfg_perf_counters u_perf (
        .i_clk, .i_rstn, .i_start_accept(start_accept), .i_done_flag(done_flag),
        .i_pipeline_en, .i_pop_en, .o_cycles(cycles), .o_stalls(stalls)
    );

    cfg_sram_select u_sram_sel (
        .i_clk, .i_rstn, .i_start_accept(start_accept),
        .i_mem_switch_edge(mem_switch_edge), .i_mem_keep(mem_keep), .o_sram_select
    );

    cfg_shadow_regs u_shadow (
        .i_clk, .i_rstn, .i_data_in, .i_wmask, .i_we_con(we_con),
        .i_word_idx(word_idx), .i_start_accept(start_accept), .o_con_word(con_word),
        .o_incntlim, .o_act_reps, .o_wei_reps, .o_thres,
        .o_sram_deepsleep, .o_sram_powergate
    );

endmodule

`default_nettype wire

/* sim/tb_cfg_regs.sv */
// Needs sim/cfg_stim.txt from the project root; i_done is held high out of reset so start is accepted
`timescale 1ns/1ps
`default_nettype none

module tb_cfg_regs;
    import cfg_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_OPS    = 256;

    logic                 i_clk;
    logic                 i_rstn;
    logic [ADR_W-1:0]     i_address;
    logic [DATA_W-1:0]    i_data_in;
    logic [DATA_W-1:0]    i_wmask;
    logic                 i_wren;
    logic                 i_rden;
    logic                 i_done;
    logic                 i_act_deadlock;
    logic                 i_wei_deadlock;
    logic                 i_feed_deadlock;
    logic [CODE_W-1:0]    i_ctx_status;
    logic [CODE_W-1:0]    i_feed_status;
    logic [CODE_W-1:0]    i_out_status;
    logic                 i_pipeline_en;
    logic                 i_pop_en;
    logic [DATA_W-1:0]    o_data_out;
    logic                 o_start;
    logic                 o_soft_reset;
    logic                 o_doneintr;
    logic [SRAM_N-1:0]    o_sram_select;
    logic [ACT_IDX_W-1:0] o_incntlim;
    logic [OUT_IDX_W-1:0] o_act_reps;
    logic [OUT_IDX_W-1:0] o_wei_reps;
    logic [TH_W-1:0]      o_thres;
    logic                 o_sram_deepsleep;
    logic                 o_sram_powergate;

    // Operation table loaded from the stim file
    logic [7:0]  op_code [MAX_OPS];
    logic [31:0] op_addr [MAX_OPS];
    logic [31:0] op_data [MAX_OPS];
    logic [31:0] op_mask [MAX_OPS];
    logic [31:0] op_exp  [MAX_OPS];
    int          n_ops = 0;

    cfg_regs_top dut_i (.*);

    // *******************************************************************
    // Clock and watchdog
    // *******************************************************************
    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD/2) i_clk = ~i_clk;
    end

    initial begin
        @(posedge i_rstn);                          // Stim table is complete by now
        #(n_ops * 20 * CLK_PERIOD);                 // 20 cycles per stim line
        $display("Watchdog expired before the stim file was finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    // Compare one value, stop at the first difference
    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, act, exp);
            $display("Test failed");
            $fatal(1, "compare error");
        end
    endtask

    // Output picked by the selector column of a C line
    function automatic logic [31:0] output_value(input logic [31:0] sel);
        case (sel)
            0:       return 32'(o_incntlim);
            1:       return 32'(o_act_reps);
            2:       return 32'(o_wei_reps);
            3:       return 32'(o_thres);
            4:       return 32'(o_sram_deepsleep);
            5:       return 32'(o_sram_powergate);
            6:       return 32'(o_sram_select);
            7:       return 32'(o_start);
            8:       return 32'(o_soft_reset);
            default: return 32'(o_doneintr);
        endcase
    endfunction

    function automatic string output_name(input logic [31:0] sel);
        case (sel)
            0:       return "o_incntlim";
            1:       return "o_act_reps";
            2:       return "o_wei_reps";
            3:       return "o_thres";
            4:       return "o_sram_deepsleep";
            5:       return "o_sram_powergate";
            6:       return "o_sram_select";
            7:       return "o_start";
            8:       return "o_soft_reset";
            default: return "o_doneintr";
        endcase
    endfunction

    task automatic load_stim();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("sim/cfg_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/cfg_stim.txt");
            $display("Test failed");
            $fatal(1, "no stim file");
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (cnt > 1 && line[0] != "#" && n_ops < MAX_OPS) begin      // Skip comments
                cnt = $sscanf(line, "%c %h %h %h %h", op_code[n_ops], op_addr[n_ops],
                              op_data[n_ops], op_mask[n_ops], op_exp[n_ops]);
                if (cnt == 5) begin
                    n_ops++;
                end else begin
                    $display("A stimulus line has not five fields: %s", line);
                    $display("Test failed");
                    $fatal(1, "bad stim line");
                end
            end
        end
        $fclose(fd);
        if (n_ops == 0) begin
            $display("The stimulus file holds no operations");
            $display("Test failed");
            $fatal(1, "empty stim");
        end
    endtask

    // *******************************************************************
    // Stimulus, all inputs change on the falling edge
    // *******************************************************************
    initial begin
        logic [31:0] fill;
        void'($urandom(32'h3d40caea));
        i_rstn = 1'b0;
        i_address = '0;
        i_data_in = '0;
        i_wmask = '0;
        i_wren = 1'b0;
        i_rden = 1'b0;
        i_done = 1'b1;                              // Datapath idle
        i_act_deadlock = 1'b1;
        i_wei_deadlock = 1'b0;
        i_feed_deadlock = 1'b1;
        i_ctx_status = 5'h03;
        i_feed_status = 5'h0a;
        i_out_status = 5'h11;
        i_pipeline_en = 1'b1;
        i_pop_en = 1'b1;
        load_stim();
        repeat (16) @(negedge i_clk);
        i_rstn = 1'b1;
        @(negedge i_clk);

        for (int k = 0; k < n_ops; k++) begin
            case (op_code[k])
                "W": begin
                    fill = $urandom();              // Masked-off bits must not matter
                    i_address = op_addr[k][ADR_W-1:0];
                    i_data_in = (op_data[k] & op_mask[k]) | (fill & ~op_mask[k]);
                    i_wmask = op_mask[k];
                    i_wren = 1'b1;
                    @(negedge i_clk);
                    i_wren = 1'b0;
                end
                "R": begin
                    i_address = op_addr[k][ADR_W-1:0];
                    i_rden = 1'b1;
                    @(negedge i_clk);
                    i_rden = 1'b0;
                    check_value($sformatf("o_data_out@%h", op_addr[k][7:0]),
                                o_data_out, op_exp[k]);
                end
                "D": begin
                    i_done = op_data[k][0];
                    @(negedge i_clk);
                end
                "P": begin
                    i_pop_en = op_data[k][0];
                    @(negedge i_clk);
                end
                "I": repeat (op_data[k]) @(negedge i_clk);
                "C": begin
                    check_value(output_name(op_addr[k]), output_value(op_addr[k]),
                                op_exp[k]);
                    @(negedge i_clk);
                end
                default: begin
                    $display("Unknown operation on stim line %0d", k);
                    $display("Test failed");
                    $fatal(1, "bad stim");
                end
            endcase
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/cfg_stim.txt */
# op addr data mask expect (hex); W write, R read, D set i_done, P set i_pop_en
# I idle data cycles, C check output selected by addr (0..9)
R 00 0 0 AC00000C
R 10 0 0 00022A1D
R 1C 0 0 2BADADD2
R 40 0 0 2BADADD2
R 28 0 0 2BADADD2
W 04 00000001 00000001 0
R 04 0 0 00000001
W 08 00000001 00000000 0
R 08 0 0 00000000
W 00 00020080 000E0080 0
R 00 0 0 AC02008C
W 20 12345678 FFFFFFFF 0
W 24 0001ABCD FFFFFFFF 0
R 20 0 0 12345678
R 24 0 0 0001ABCD
W 24 FFFF0000 00FF0000 0
R 24 0 0 00FFABCD
C 0 0 0 0
C 3 0 0 0
# Start, then the shadow fields and SRAM selects update
W 00 00000001 00000001 0
C 7 0 0 1
C 7 0 0 0
C 6 0 0 6
C 0 0 0 5678
C 1 0 0 2468
C 2 0 0 2F34
C 3 0 0 1
C 4 0 0 1
C 5 0 0 1
# Six stalled cycles, then completion
P 0 0 0 0
I 0 5 0 0
P 0 1 0 0
D 0 0 0 0
I 0 2 0 0
D 0 1 0 0
I 0 3 0 0
R 00 0 0 AC02008E
R 0C 0 0 00000001
C 9 0 0 0
W 08 00000001 00000001 0
C 9 0 0 1
W 0C 00000001 00000001 0
C 9 0 0 0
R 0C 0 0 00000000
W 00 00000002 00000002 0
R 00 0 0 AC02008C
R 18 0 0 00000006
R 14 0 0 00000015
# Memory switch without a start
W 00 00010000 00010000 0
C 6 0 0 6
C 6 0 0 0
C 0 0 0 5678
# Soft reset pulse
W 00 00800000 00800000 0
C 8 0 0 1
C 8 0 0 0
R 00 0 0 AC02008C

/* tb.f */
hdl/cfg_pkg.sv
hdl/cfg_bus_decode.sv
hdl/cfg_ctrl_regs.sv
hdl/cfg_perf_counters.sv
hdl/cfg_sram_select.sv
hdl/cfg_shadow_regs.sv
hdl/cfg_regs_top.sv
sim/tb_cfg_regs.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_cfg_regs
FILELIST := tb.f
LOG      := sim.log
FAIL_MSG := Test failed
PASS_MSG := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
